/* bench/sm83_disasm_assertions.sv */
// output protocol assertions for the disassembler, bound into the top level by the testbench.
`include "sm83_disasm_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module sm83_disasm_assertions (
    input logic                                    clk,
    input logic                                    rst_n,
    input logic                                    req_valid,
    input logic                                    str_valid,
    input logic [`SM83_STR_CHARS*`SM83_CHAR_W-1:0] opcode_str
);

    int failures = 0;

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !str_valid)
        else begin
            $error("str_valid high while rst_n is low");
            failures++;
        end

    // two-stage pipe, one result per request.
    result_follows: assert property (@(posedge clk) disable iff (!rst_n)
                                     req_valid |-> ##2 str_valid)
        else begin
            $error("request not answered two cycles later");
            failures++;
        end

    no_stray_result: assert property (@(posedge clk) disable iff (!rst_n)
                                      str_valid |-> $past(req_valid, 2))
        else begin
            $error("str_valid without a request two cycles earlier");
            failures++;
        end

    held_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
                                     !str_valid |-> $stable(opcode_str))
        else begin
            $error("opcode_str changed while str_valid is low");
            failures++;
        end

endmodule

`default_nettype wire

/* bench/sm83_disasm_checker.sv */
// bench checker; predicts each string from the SM83 table rules and compares in request order.
`include "sm83_disasm_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module sm83_disasm_checker (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    req_valid,
    input  sm83_disasm_pkg::op_req_t                req,
    input  logic                                    str_valid,
    input  logic [`SM83_STR_CHARS*`SM83_CHAR_W-1:0] opcode_str,
    input  logic                                    end_of_test,
    output int                                      results,
    output int                                      unchecked,
    output int                                      value_errors,
    output int                                      protocol_errors,
    output int                                      outstanding
);

    localparam int CHAR_W = `SM83_CHAR_W;
    localparam int STR_W  = `SM83_STR_CHARS * `SM83_CHAR_W;

    string reg_names [8]   = '{"B", "C", "D", "E", "H", "L", "(HL)", "A"};
    string alu_names [8]   = '{"ADD", "ADC", "SUB", "SBC", "AND", "XOR", "OR", "CP"};
    string shift_names [8] = '{"RLC", "RRC", "RL", "RR", "SLA", "SRA", "SWAP", "SRL"};
    string bit_names [4]   = '{"", "BIT", "RES", "SET"};

    sm83_disasm_pkg::op_req_t pending [$];
    bit                       seen_result = 1'b0;
    bit                       end_seen    = 1'b0;

    function automatic string hex_byte(input logic [7:0] v);
        string digits;
        digits = "0123456789ABCDEF";
        return $sformatf("%s%s", digits.substr(int'(v[7:4]), int'(v[7:4])),
                         digits.substr(int'(v[3:0]), int'(v[3:0])));
    endfunction

    // irregular base rows are known only at the checkpoints.
    function automatic bit expected_text(input sm83_disasm_pkg::op_req_t r, output string s);
        logic [7:0] op;
        logic [2:0] hi;
        logic [2:0] lo;
        bit         known;
        op    = r.opcode;
        hi    = op[5:3];
        lo    = op[2:0];
        known = 1'b1;
        s     = "";
        if (r.prefixed && op[7:6] == 2'b00) begin
            s = $sformatf("%s %s", shift_names[hi], reg_names[lo]);
        end else if (r.prefixed) begin
            s = $sformatf("%s %0d %s", bit_names[op[7:6]], hi, reg_names[lo]);
        end else if (op == 8'h76) begin
            s = "HALT";
        end else if (op[7:6] == 2'b01) begin
            s = $sformatf("LD %s %s", reg_names[hi], reg_names[lo]);
        end else if (op[7:6] == 2'b10 && hi inside {3'd0, 3'd1, 3'd3}) begin
            s = $sformatf("%s A %s", alu_names[hi], reg_names[lo]);
        end else if (op[7:6] == 2'b10) begin
            s = $sformatf("%s %s", alu_names[hi], reg_names[lo]);
        end else begin
            case (op)
                8'h00: s = "NOP";
                8'h10: s = "STOP";
                8'h22: s = "LD (HL+) A";
                8'hCB: s = "PREFIX";
                8'hC9: s = "RET";
                8'hE0: s = "LDH (a8) A";
                8'hFF: s = "RST 38H";
                8'hD3, 8'hDB, 8'hDD, 8'hE3, 8'hE4, 8'hEB, 8'hEC, 8'hED, 8'hF4, 8'hFC, 8'hFD:
                    s = $sformatf("ILLEGAL_%s", hex_byte(op));
                default: known = 1'b0;
            endcase
        end
        return known;
    endfunction

    // last character in byte 0, zeros above.
    function automatic logic [STR_W-1:0] right_align(input string s);
        logic [STR_W-1:0] r;
        r = '0;
        for (int i = 0; i < s.len(); i++) begin
            r = {r[STR_W-CHAR_W-1:0], s[i]};
        end
        return r;
    endfunction

    always @(posedge clk) begin : compare
        sm83_disasm_pkg::op_req_t head;
        string                    text;
        logic [STR_W-1:0]         want;
        if (rst_n) begin
            if (str_valid && pending.size() == 0) begin
                $display("str_valid went high with no request outstanding");
                protocol_errors++;
            end else if (str_valid) begin
                seen_result = 1'b1;
                head        = pending.pop_front();
                results++;
                if (expected_text(head, text)) begin
                    want = right_align(text);
                    if (opcode_str !== want) begin
                        $display("[ERROR] opcode_str (prefixed %0d opcode 0x%02h): %s 0x%h, got 0x%h",
                                 head.prefixed, head.opcode, "expected", want, opcode_str);
                        value_errors++;
                    end
                end else begin
                    unchecked++;
                end
            end else if (!seen_result && opcode_str !== '0) begin
                $display("[ERROR] opcode_str before first result: expected 0x0, got 0x%h",
                         opcode_str);
                value_errors++;
            end
            if (req_valid) begin
                pending.push_back(req);
            end
            if (end_of_test && !end_seen) begin
                end_seen = 1'b1;
                if (pending.size() != 0) begin
                    $display("%0d requests never produced a result", pending.size());
                    protocol_errors += pending.size();
                end
            end
        end
        outstanding = pending.size();
    end

endmodule

`default_nettype wire

/* bench/sm83_disasm_tb.sv */
// top-level testbench; sweeps both SM83 tables, then random gapped requests, and prints the verdict.
`include "sm83_disasm_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module sm83_disasm_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int SWEEP_REQS   = 512;
    localparam int RANDOM_REQS  = 300;
    localparam int LIMIT_CYCLES = RESET_CYCLES + SWEEP_REQS + 2 * RANDOM_REQS + 50;

    logic                                    clk;
    logic                                    rst_n;
    logic                                    req_valid;
    sm83_disasm_pkg::op_req_t                req;
    logic                                    str_valid;
    logic [`SM83_STR_CHARS*`SM83_CHAR_W-1:0] opcode_str;
    logic                                    end_of_test;
    int                                      results;
    int                                      unchecked;
    int                                      value_errors;
    int                                      protocol_errors;
    int                                      outstanding;
    int                                      seed;
    logic [31:0]                             rnd;

    sm83_disasm uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .str_valid  (str_valid),
        .opcode_str (opcode_str)
    );

    sm83_disasm_checker u_checker (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid       (req_valid),
        .req             (req),
        .str_valid       (str_valid),
        .opcode_str      (opcode_str),
        .end_of_test     (end_of_test),
        .results         (results),
        .unchecked       (unchecked),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .outstanding     (outstanding)
    );

    bind sm83_disasm sm83_disasm_assertions u_assert (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .str_valid  (str_valid),
        .opcode_str (opcode_str)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("tests failed");
        $finish;
    end

    task automatic send_request(input logic prefixed, input logic [7:0] opcode);
        req_valid    <= 1'b1;
        req.prefixed <= prefixed;
        req.opcode   <= opcode;
        @(posedge clk);
    endtask

    task automatic idle_cycles(input int n);
        req_valid <= 1'b0;
        rnd        = $random(seed);
        req       <= sm83_disasm_pkg::op_req_t'(rnd[8:0]); // junk the DUT must ignore.
        repeat (n) @(posedge clk);
    endtask

    initial begin : stimulus
        int assert_failures;
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        end_of_test = 1'b0;
        seed        = 93043;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycles(4); // output must stay zero here.
        for (int p = 0; p < 2; p++) begin
            for (int op = 0; op < 256; op++) begin
                send_request(1'(p), 8'(op)); // back to back.
            end
        end
        for (int n = 0; n < RANDOM_REQS; n++) begin
            rnd = $random(seed);
            send_request(rnd[8], rnd[7:0]);
            if (rnd[9]) begin
                idle_cycles(1);
            end
        end
        req_valid <= 1'b0;
        @(negedge clk);
        for (int w = 0; w < 8 && outstanding != 0; w++) begin
            @(negedge clk); // results are due two cycles after the last request.
        end
        repeat (3) @(posedge clk);
        end_of_test <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        assert_failures = uut.u_assert.failures;
        $display("results %0d of %0d, unchecked %0d, value errors %0d, protocol errors %0d, %s %0d",
                 results, SWEEP_REQS + RANDOM_REQS, unchecked, value_errors, protocol_errors,
                 "assertion failures", assert_failures);
        if (value_errors == 0 && protocol_errors == 0 && assert_failures == 0 &&
            results == SWEEP_REQS + RANDOM_REQS) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the disassembler testbench with Verilator, verdict taken from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module sm83_disasm_tb -f sm83_disasm.f \
    -Mdir obj_dir -o sm83_disasm_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sm83_disasm_sim +verilator+error+limit+1000 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "all tests passed" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* sm83_disasm.f */
+incdir+src
src/sm83_disasm_pkg.sv
src/base_op_decoder.sv
src/cb_op_decoder.sv
src/mnemonic_renderer.sv
src/sm83_disasm.sv
bench/sm83_disasm_assertions.sv
bench/sm83_disasm_checker.sv
bench/sm83_disasm_tb.sv

/* src/base_op_decoder.sv */
// unprefixed SM83 table; registers the tokens of opcode one cycle after it is presented.
`include "sm83_disasm_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module base_op_decoder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`SM83_OP_W-1:0]       opcode,
    output sm83_disasm_pkg::op_tokens_t tokens
);

    sm83_disasm_pkg::op_tokens_t t;
    sm83_disasm_pkg::mnem_e      alu;
    sm83_disasm_pkg::operand_e   alu_src;
    sm83_disasm_pkg::operand_e   reg_dst;
    sm83_disasm_pkg::operand_e   reg_src;
    sm83_disasm_pkg::operand_e   cond;
    sm83_disasm_pkg::operand_e   pair;
    sm83_disasm_pkg::operand_e   stack_pair;
    sm83_disasm_pkg::operand_e   ptr;

    function automatic sm83_disasm_pkg::op_tokens_t tok(
        input sm83_disasm_pkg::mnem_e    m,
        input sm83_disasm_pkg::operand_e a = sm83_disasm_pkg::OP_NONE,
        input sm83_disasm_pkg::operand_e b = sm83_disasm_pkg::OP_NONE
    );
        sm83_disasm_pkg::op_tokens_t r;
        r      = '0;
        r.mnem = m;
        r.opd1 = a;
        r.opd2 = b;
        return r;
    endfunction

    always_comb begin
        alu     = sm83_disasm_pkg::mnem_e'(6'(sm83_disasm_pkg::MN_ADD) + 6'(opcode[5:3]));
        alu_src = opcode[6] ? sm83_disasm_pkg::OP_D8 : sm83_disasm_pkg::reg_operand(opcode[2:0]);
        reg_dst = sm83_disasm_pkg::reg_operand(opcode[5:3]);
        reg_src = sm83_disasm_pkg::reg_operand(opcode[2:0]);
        cond    = (opcode[4:3] == 2'd3) ? sm83_disasm_pkg::OP_C :
                  sm83_disasm_pkg::operand_e'(6'(sm83_disasm_pkg::OP_NZ) + 6'(opcode[4:3]));
        pair    = sm83_disasm_pkg::operand_e'(6'(sm83_disasm_pkg::OP_BC) + 6'(opcode[5:4]));
        stack_pair = (opcode[5:4] == 2'd3) ? sm83_disasm_pkg::OP_AF : pair; // AF in SP slot.
        ptr     = sm83_disasm_pkg::operand_e'(6'(sm83_disasm_pkg::OP_BC_IND) + 6'(opcode[5:4]));
        casez (opcode)
            8'h00: t = tok(sm83_disasm_pkg::MN_NOP);
            8'h08: t = tok(sm83_disasm_pkg::MN_LD, sm83_disasm_pkg::OP_A16_IND,
                           sm83_disasm_pkg::OP_SP);
            8'h10: t = tok(sm83_disasm_pkg::MN_STOP);
            8'h18: t = tok(sm83_disasm_pkg::MN_JR, sm83_disasm_pkg::OP_R8);
            8'b001?_?000: t = tok(sm83_disasm_pkg::MN_JR, cond, sm83_disasm_pkg::OP_R8);
            8'b00??_0001: t = tok(sm83_disasm_pkg::MN_LD, pair, sm83_disasm_pkg::OP_D16);
            8'b00??_0010: t = tok(sm83_disasm_pkg::MN_LD, ptr, sm83_disasm_pkg::OP_A);
            8'b00??_1010: t = tok(sm83_disasm_pkg::MN_LD, sm83_disasm_pkg::OP_A, ptr);
            8'b00??_0011: t = tok(sm83_disasm_pkg::MN_INC, pair);
            8'b00??_1011: t = tok(sm83_disasm_pkg::MN_DEC, pair);
            8'b00??_1001: t = tok(sm83_disasm_pkg::MN_ADD, sm83_disasm_pkg::OP_HL, pair);
            8'b00??_?100: t = tok(sm83_disasm_pkg::MN_INC, reg_dst);
            8'b00??_?101: t = tok(sm83_disasm_pkg::MN_DEC, reg_dst);
            8'b00??_?110: t = tok(sm83_disasm_pkg::MN_LD, reg_dst, sm83_disasm_pkg::OP_D8);
            8'b00??_?111: begin
                t = tok(sm83_disasm_pkg::mnem_e'(6'(sm83_disasm_pkg::MN_RLCA) + 6'(opcode[5:3])));
            end
            8'b01??_????: begin
                // LD (HL) (HL) slot is HALT.
                t = (opcode == 8'h76) ? tok(sm83_disasm_pkg::MN_HALT) :
                    tok(sm83_disasm_pkg::MN_LD, reg_dst, reg_src);
            end
            8'b10??_????, 8'b11??_?110: begin
                if (opcode[5:3] inside {3'd0, 3'd1, 3'd3}) begin
                    t = tok(alu, sm83_disasm_pkg::OP_A, alu_src); // ADD ADC SBC name A.
                end else begin
                    t = tok(alu, alu_src);
                end
            end
            8'b11??_?111: begin
                t = tok(sm83_disasm_pkg::MN_RST,
                        sm83_disasm_pkg::operand_e'(6'(sm83_disasm_pkg::OP_RST00) +
                                                    6'(opcode[5:3])));
            end
            8'b110?_?000: t = tok(sm83_disasm_pkg::MN_RET, cond);
            8'hE0: t = tok(sm83_disasm_pkg::MN_LDH, sm83_disasm_pkg::OP_A8_IND,
                           sm83_disasm_pkg::OP_A);
            8'hE8: t = tok(sm83_disasm_pkg::MN_ADD, sm83_disasm_pkg::OP_SP, sm83_disasm_pkg::OP_R8);
            8'hF0: t = tok(sm83_disasm_pkg::MN_LDH, sm83_disasm_pkg::OP_A,
                           sm83_disasm_pkg::OP_A8_IND);
            8'hF8: t = tok(sm83_disasm_pkg::MN_LD, sm83_disasm_pkg::OP_HL, sm83_disasm_pkg::OP_SP);
            8'b11??_0001: t = tok(sm83_disasm_pkg::MN_POP, stack_pair);
            8'b11??_0101: t = tok(sm83_disasm_pkg::MN_PUSH, stack_pair);
            8'hC9: t = tok(sm83_disasm_pkg::MN_RET);
            8'hD9: t = tok(sm83_disasm_pkg::MN_RETI);
            8'hE9: t = tok(sm83_disasm_pkg::MN_JP, sm83_disasm_pkg::OP_HL);
            8'hF9: t = tok(sm83_disasm_pkg::MN_LD, sm83_disasm_pkg::OP_SP, sm83_disasm_pkg::OP_HL);
            8'b110?_?010: t = tok(sm83_disasm_pkg::MN_JP, cond, sm83_disasm_pkg::OP_A16);
            8'hE2: t = tok(sm83_disasm_pkg::MN_LD, sm83_disasm_pkg::OP_C_IND, sm83_disasm_pkg::OP_A);
            8'hF2: t = tok(sm83_disasm_pkg::MN_LD, sm83_disasm_pkg::OP_A, sm83_disasm_pkg::OP_C_IND);
            8'hEA: t = tok(sm83_disasm_pkg::MN_LD, sm83_disasm_pkg::OP_A16_IND,
                           sm83_disasm_pkg::OP_A);
            8'hFA: t = tok(sm83_disasm_pkg::MN_LD, sm83_disasm_pkg::OP_A,
                           sm83_disasm_pkg::OP_A16_IND);
            8'hC3: t = tok(sm83_disasm_pkg::MN_JP, sm83_disasm_pkg::OP_A16);
            8'hF3: t = tok(sm83_disasm_pkg::MN_DI);
            8'hCB: t = tok(sm83_disasm_pkg::MN_PREFIX);
            8'hFB: t = tok(sm83_disasm_pkg::MN_EI);
            8'b110?_?100: t = tok(sm83_disasm_pkg::MN_CALL, cond, sm83_disasm_pkg::OP_A16);
            8'hCD: t = tok(sm83_disasm_pkg::MN_CALL, sm83_disasm_pkg::OP_A16);
            default: t = tok(sm83_disasm_pkg::MN_ILLEGAL); // the eleven holes.
        endcase
        t.opcode = opcode;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tokens <= '0;
        end else begin
            tokens <= t;
        end
    end

endmodule

`default_nettype wire

/* src/cb_op_decoder.sv */
// CB-prefixed SM83 table; registers tokens from the opcode bit fields one cycle later.
`include "sm83_disasm_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module cb_op_decoder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`SM83_OP_W-1:0]       opcode,
    output sm83_disasm_pkg::op_tokens_t tokens
);

    sm83_disasm_pkg::op_tokens_t t;

    always_comb begin
        t        = '0;
        t.opcode = opcode;
        if (opcode[7:6] == 2'b00) begin
            // rotates and shifts.
            t.mnem = sm83_disasm_pkg::mnem_e'(6'(sm83_disasm_pkg::MN_RLC) + 6'(opcode[5:3]));
            t.opd1 = sm83_disasm_pkg::reg_operand(opcode[2:0]);
        end else begin
            t.mnem    = sm83_disasm_pkg::mnem_e'(6'(sm83_disasm_pkg::MN_BIT) +
                                                 6'(opcode[7:6]) - 6'd1);
            t.opd1    = sm83_disasm_pkg::OP_BITNUM; // spelled from bit_num.
            t.opd2    = sm83_disasm_pkg::reg_operand(opcode[2:0]);
            t.bit_num = opcode[5:3];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tokens <= '0;
        end else begin
            tokens <= t;
        end
    end

endmodule

`default_nettype wire

/* src/mnemonic_renderer.sv */
// output stage; picks the decoder result by prefix and spells it as right-aligned ascii.
`include "sm83_disasm_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module mnemonic_renderer (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    req_valid,
    input  logic                                    prefixed,
    input  sm83_disasm_pkg::op_tokens_t             base_tokens,
    input  sm83_disasm_pkg::op_tokens_t             cb_tokens,
    output logic                                    str_valid,
    output logic [`SM83_STR_CHARS*`SM83_CHAR_W-1:0] opcode_str
);

    localparam int CHAR_W = `SM83_CHAR_W;
    localparam int STR_W  = `SM83_STR_CHARS * `SM83_CHAR_W;
    localparam int WORD_W = 7 * CHAR_W; // ILLEGAL is the longest word.

    // indexed by mnem_e and operand_e, same order.
    localparam logic [WORD_W-1:0] MNEM_TXT [46] = '{
        "NOP", "LD", "LDH", "INC", "DEC", "ADD", "ADC", "SUB", "SBC", "AND", "XOR", "OR",
        "CP", "JR", "JP", "CALL", "RET", "RETI", "RST", "PUSH", "POP", "RLC", "RRC", "RL",
        "RR", "SLA", "SRA", "SWAP", "SRL", "BIT", "RES", "SET", "HALT", "STOP", "DI", "EI",
        "RLCA", "RRCA", "RLA", "RRA", "DAA", "CPL", "SCF", "CCF", "PREFIX", "ILLEGAL"
    };
    localparam logic [WORD_W-1:0] OPD_TXT [37] = '{
        '0, "B", "C", "D", "E", "H", "L", "(HL)", "A", "BC", "DE", "HL", "SP", "AF",
        "(BC)", "(DE)", "(HL+)", "(HL-)", "(C)", "d8", "d16", "r8", "a16", "(a8)", "(a16)",
        "NZ", "Z", "NC", "00H", "08H", "10H", "18H", "20H", "28H", "30H", "38H", '0
    };

    logic                        valid_q;
    logic                        prefixed_q;
    sm83_disasm_pkg::op_tokens_t tok;
    logic [STR_W-1:0]            text;

    // appending shifts earlier text up, so the last character lands in byte 0.
    function automatic logic [STR_W-1:0] push_word(input logic [STR_W-1:0]  s,
                                                   input logic [WORD_W-1:0] w);
        logic [STR_W-1:0] r;
        r = s;
        for (int i = WORD_W / CHAR_W - 1; i >= 0; i--) begin
            if (w[i*CHAR_W +: CHAR_W] != '0) begin
                r = {r[STR_W-CHAR_W-1:0], w[i*CHAR_W +: CHAR_W]};
            end
        end
        return r;
    endfunction

    function automatic logic [CHAR_W-1:0] hex_char(input logic [3:0] n);
        return (n < 4'd10) ? 8'h30 + 8'(n) : 8'h37 + 8'(n); // upper case.
    endfunction

    function automatic logic [STR_W-1:0] push_operand(input logic [STR_W-1:0]         s,
                                                      input sm83_disasm_pkg::operand_e opd,
                                                      input logic [2:0]               bit_num);
        logic [STR_W-1:0] r;
        r = s;
        if (opd != sm83_disasm_pkg::OP_NONE) begin
            r = {r[STR_W-CHAR_W-1:0], 8'h20}; // single space.
            if (opd == sm83_disasm_pkg::OP_BITNUM) begin
                r = {r[STR_W-CHAR_W-1:0], 8'h30 + 8'(bit_num)};
            end else begin
                r = push_word(r, OPD_TXT[opd]);
            end
        end
        return r;
    endfunction

    always_comb begin
        tok  = prefixed_q ? cb_tokens : base_tokens;
        text = push_word('0, MNEM_TXT[tok.mnem]);
        if (tok.mnem == sm83_disasm_pkg::MN_ILLEGAL) begin
            text = push_word(text, WORD_W'({"_", hex_char(tok.opcode[7:4]),
                                            hex_char(tok.opcode[3:0])}));
        end
        text = push_operand(text, tok.opd1, tok.bit_num);
        text = push_operand(text, tok.opd2, tok.bit_num);
    end

    // valid and prefix line up with the registered tokens.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q    <= 1'b0;
            prefixed_q <= 1'b0;
            str_valid  <= 1'b0;
            opcode_str <= '0;
        end else begin
            valid_q    <= req_valid;
            prefixed_q <= prefixed;
            str_valid  <= valid_q;
            if (valid_q) begin
                opcode_str <= text; // held between requests.
            end
        end
    end

endmodule

`default_nettype wire

/* src/sm83_disasm.sv */
// SM83 debug disassembler top; a request strobed on req_valid shows up on opcode_str two cycles later.
`include "sm83_disasm_defines.svh"
`timescale 1ns/1ps
`default_nettype none

module sm83_disasm (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    req_valid,
    input  sm83_disasm_pkg::op_req_t                req,
    output logic                                    str_valid,
    output logic [`SM83_STR_CHARS*`SM83_CHAR_W-1:0] opcode_str
);

    sm83_disasm_pkg::op_tokens_t base_tokens;
    sm83_disasm_pkg::op_tokens_t cb_tokens;

    // both tables decode every cycle.
    base_op_decoder u_base (
        .clk    (clk),
        .rst_n  (rst_n),
        .opcode (req.opcode),
        .tokens (base_tokens)
    );

    cb_op_decoder u_cb (
        .clk    (clk),
        .rst_n  (rst_n),
        .opcode (req.opcode),
        .tokens (cb_tokens)
    );

    mnemonic_renderer u_render (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .prefixed    (req.prefixed),
        .base_tokens (base_tokens),
        .cb_tokens   (cb_tokens),
        .str_valid   (str_valid),
        .opcode_str  (opcode_str)
    );

endmodule

`default_nettype wire

/* src/sm83_disasm_defines.svh */
// width constants for the SM83 disassembler, included ahead of the package and every module.
`ifndef SM83_DISASM_DEFINES_SVH
`define SM83_DISASM_DEFINES_SVH

`default_nettype none

// opcode byte.
`define SM83_OP_W 8

`define SM83_CHAR_W 8     // one ascii character.
`define SM83_STR_CHARS 24 // display field, right aligned.

`default_nettype wire

`endif

/* src/sm83_disasm_pkg.sv */
// token types shared by the SM83 decoders, the renderer and the bench; reached by scoped names.
`include "sm83_disasm_defines.svh"
`default_nettype none

package sm83_disasm_pkg;

    // runs of consecutive words are indexed by opcode fields.
    typedef enum logic [5:0] {
        MN_NOP, MN_LD, MN_LDH, MN_INC, MN_DEC,
        MN_ADD, MN_ADC, MN_SUB, MN_SBC, MN_AND, MN_XOR, MN_OR, MN_CP,
        MN_JR, MN_JP, MN_CALL, MN_RET, MN_RETI, MN_RST, MN_PUSH, MN_POP,
        MN_RLC, MN_RRC, MN_RL, MN_RR, MN_SLA, MN_SRA, MN_SWAP, MN_SRL,
        MN_BIT, MN_RES, MN_SET,
        MN_HALT, MN_STOP, MN_DI, MN_EI,
        MN_RLCA, MN_RRCA, MN_RLA, MN_RRA, MN_DAA, MN_CPL, MN_SCF, MN_CCF,
        MN_PREFIX, MN_ILLEGAL
    } mnem_e;

    typedef enum logic [5:0] {
        OP_NONE,
        OP_B, OP_C, OP_D, OP_E, OP_H, OP_L, OP_HL_IND, OP_A, // register field order.
        OP_BC, OP_DE, OP_HL, OP_SP, OP_AF,
        OP_BC_IND, OP_DE_IND, OP_HLI_IND, OP_HLD_IND, OP_C_IND,
        OP_D8, OP_D16, OP_R8, OP_A16, OP_A8_IND, OP_A16_IND,
        OP_NZ, OP_Z, OP_NC,                                  // condition C reuses OP_C.
        OP_RST00, OP_RST08, OP_RST10, OP_RST18,
        OP_RST20, OP_RST28, OP_RST30, OP_RST38,
        OP_BITNUM
    } operand_e;

    typedef struct packed {
        logic                  prefixed;
        logic [`SM83_OP_W-1:0] opcode;
    } op_req_t;

    typedef struct packed {
        mnem_e                 mnem;
        operand_e              opd1;
        operand_e              opd2;
        logic [2:0]            bit_num;
        logic [`SM83_OP_W-1:0] opcode; // source of the illegal hex suffix.
    } op_tokens_t;

    // 3-bit register field, B C D E H L (HL) A.
    function automatic operand_e reg_operand(input logic [2:0] f);
        return operand_e'(6'(OP_B) + 6'(f));
    endfunction

endpackage

`default_nettype wire
